// File: logic/rob_pkg.sv
package rob_pkg;

    // ------------------------------------------------------------------
    // sizes
    // ------------------------------------------------------------------

    localparam int rob_size  = 16;
    localparam int rob_idx_w = 4;
    localparam int areg_w    = 5;
    localparam int preg_w    = 6;
    localparam int pc_w      = 39;
    localparam int num_areg  = 32;

    // completing units and their slots in the done array
    localparam int num_fu  = 5;
    localparam int fu_alu1 = 0;
    localparam int fu_alu2 = 1;
    localparam int fu_lsu  = 2;

    // units whose writeback needs the rd looked up
    localparam int num_wb = 3;

    // ------------------------------------------------------------------
    // types
    // ------------------------------------------------------------------

    // one decode slot, already renamed by the RAT
    typedef struct packed {
        logic [pc_w-1:0]   pc;
        logic              uses_rs1;
        logic              uses_rs2;
        logic              uses_rd;
        logic [areg_w-1:0] rs1;
        logic [areg_w-1:0] rs2;
        logic [areg_w-1:0] rd;
        logic              mret;
        logic              sret;
        logic              wfi;
        logic [preg_w-1:0] prs1;
        logic [preg_w-1:0] prs2;
        logic [preg_w-1:0] lprd;
        logic [preg_w-1:0] prd;
    } decode_req_t;

    typedef struct packed {
        logic [rob_idx_w-1:0] rob_idx;
        logic [preg_w-1:0]    prd;
        logic [preg_w-1:0]    prs1;
        logic [preg_w-1:0]    prs2;
        logic                 rs1_wait;
        logic                 rs2_wait;
        logic [pc_w-1:0]      pc;
    } issue_pkt_t;

    // captured by an entry on allocation
    typedef struct packed {
        logic [preg_w-1:0] lprd;
        logic [areg_w-1:0] rd;
        logic [pc_w-1:0]   pc;
        logic              skip;
    } entry_wr_t;

    typedef struct packed {
        logic              used;
        logic              finish;
        logic [preg_w-1:0] lprd;
        logic [areg_w-1:0] rd;
        logic [pc_w-1:0]   pc;
    } entry_view_t;

    typedef struct packed {
        logic                 valid;
        logic [rob_idx_w-1:0] idx;
    } fu_done_t;

endpackage

// File: logic/rob_entry.sv
`timescale 1ns/100ps

module rob_entry #(
    parameter int entry_idx = 0
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [1:0]                           wr_en_i,
    input  rob_pkg::entry_wr_t [1:0]             wr_data_i,
    input  rob_pkg::fu_done_t [rob_pkg::num_fu-1:0] fu_done_i,
    input  logic                                 commit_clr_i,
    output rob_pkg::entry_view_t                 view_o
);

    logic                        used;
    logic                        finish;
    logic [rob_pkg::preg_w-1:0]  lprd;
    logic [rob_pkg::areg_w-1:0]  rd;
    logic [rob_pkg::pc_w-1:0]    pc;

    logic                        wr_any;
    rob_pkg::entry_wr_t          wr_data;
    logic                        done_hit;

    // at most one slot targets this entry
    assign wr_any  = |wr_en_i;
    assign wr_data = wr_en_i[0] ? wr_data_i[0] : wr_data_i[1];

    // any unit reporting our index
    always_comb begin
        done_hit = 1'b0;
        for (int f = 0; f < rob_pkg::num_fu; f++) begin
            if (fu_done_i[f].valid && (int'(fu_done_i[f].idx) == entry_idx)) begin
                done_hit = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // control state
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            used   <= 1'b0;
            finish <= 1'b0;
        end else begin
            if (wr_any) begin
                used   <= 1'b1;
                finish <= wr_data.skip;
            end
            if (done_hit) begin
                finish <= 1'b1;
            end
            // commit clear wins over everything
            if (commit_clr_i) begin
                used   <= 1'b0;
                finish <= 1'b0;
            end
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (wr_any) begin
            lprd <= wr_data.lprd;
            rd   <= wr_data.rd;
            pc   <= wr_data.pc;
        end
    end

    assign view_o.used   = used;
    assign view_o.finish = finish;
    assign view_o.lprd   = lprd;
    assign view_o.rd     = rd;
    assign view_o.pc     = pc;

    // a unit must not finish an entry that was never allocated
    a_done_on_used: assert property (
        @(posedge clk) disable iff (rst)
        done_hit |-> used
    );

endmodule

// File: logic/rob_dispatch.sv
`timescale 1ns/100ps

module rob_dispatch (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          global_wfi_i,
    input  logic [1:0]                                    valid_i,
    input  rob_pkg::decode_req_t [1:0]                    req_i,
    input  logic [rob_pkg::num_areg-1:0]                  busy_table_i,
    input  logic [rob_pkg::rob_size-1:0]                  used_i,
    output logic [1:0]                                    ready_o,
    output logic [1:0][rob_pkg::rob_size-1:0]             wr_en_o,
    output rob_pkg::entry_wr_t [1:0]                      wr_data_o,
    output rob_pkg::issue_pkt_t [1:0]                     issue_o,
    output logic [1:0]                                    fl_alloc_en_o
);

    logic [rob_pkg::rob_idx_w-1:0]      wr_ptr;
    logic [rob_pkg::rob_idx_w-1:0]      ptr_step;
    logic [1:0][rob_pkg::rob_idx_w-1:0] slot_idx;
    logic [1:0]                         do_wr;
    logic                               hit_rs1;
    logic                               hit_rs2;
    logic                               hit_rd;

    // ------------------------------------------------------------------
    // write pointer and handshake
    // ------------------------------------------------------------------

    // slot two always sits one past slot one and wraps at 16
    assign slot_idx[0] = wr_ptr;
    assign slot_idx[1] = wr_ptr + 1'b1;

    // ready only looks at the target entry
    assign ready_o[0] = !used_i[slot_idx[0]];
    assign ready_o[1] = !used_i[slot_idx[1]];

    assign do_wr[0] = ready_o[0] && valid_i[0] && !global_wfi_i;
    assign do_wr[1] = ready_o[1] && valid_i[1] && !global_wfi_i;

    assign ptr_step = {{(rob_pkg::rob_idx_w-1){1'b0}}, do_wr[0]}
                    + {{(rob_pkg::rob_idx_w-1){1'b0}}, do_wr[1]};

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
        end else begin
            wr_ptr <= wr_ptr + ptr_step;
        end
    end

    // one-hot strobe per slot
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            for (int e = 0; e < rob_pkg::rob_size; e++) begin
                wr_en_o[s][e] = do_wr[s] && (int'(slot_idx[s]) == e);
            end
        end
    end

    // ------------------------------------------------------------------
    // intra-pair rename bypass
    // ------------------------------------------------------------------

    // slot two sees slot one's fresh prd before the RAT does
    assign hit_rs1 = req_i[1].uses_rs1 && req_i[0].uses_rd
                  && (req_i[1].rs1 == req_i[0].rd);
    assign hit_rs2 = req_i[1].uses_rs2 && req_i[0].uses_rd
                  && (req_i[1].rs2 == req_i[0].rd);
    assign hit_rd  = req_i[1].uses_rd && req_i[0].uses_rd
                  && (req_i[1].rd == req_i[0].rd);

    // free list pop only for a real destination
    assign fl_alloc_en_o[0] = do_wr[0] && req_i[0].uses_rd && (req_i[0].rd != '0);
    assign fl_alloc_en_o[1] = do_wr[1] && req_i[1].uses_rd && (req_i[1].rd != '0);

    // ------------------------------------------------------------------
    // entry write data and issue packets
    // ------------------------------------------------------------------

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            wr_data_o[s].pc   = req_i[s].pc;
            wr_data_o[s].rd   = req_i[s].uses_rd ? req_i[s].rd : '0;
            // mret sret wfi need no unit
            wr_data_o[s].skip = req_i[s].mret || req_i[s].sret || req_i[s].wfi;
            if ((s == 1) && hit_rd) begin
                wr_data_o[s].lprd = req_i[0].prd;
            end else if (req_i[s].uses_rd) begin
                wr_data_o[s].lprd = req_i[s].lprd;
            end else begin
                wr_data_o[s].lprd = '0;
            end

            issue_o[s].rob_idx = slot_idx[s];
            issue_o[s].pc      = req_i[s].pc;
            issue_o[s].prd     = fl_alloc_en_o[s] ? req_i[s].prd : '0;

            if ((s == 1) && hit_rs1) begin
                issue_o[s].prs1     = req_i[0].prd;
                issue_o[s].rs1_wait = 1'b1;
            end else begin
                issue_o[s].prs1     = req_i[s].uses_rs1 ? req_i[s].prs1 : '0;
                issue_o[s].rs1_wait = req_i[s].uses_rs1 && busy_table_i[req_i[s].rs1];
            end

            if ((s == 1) && hit_rs2) begin
                issue_o[s].prs2     = req_i[0].prd;
                issue_o[s].rs2_wait = 1'b1;
            end else begin
                issue_o[s].prs2     = req_i[s].uses_rs2 ? req_i[s].prs2 : '0;
                issue_o[s].rs2_wait = req_i[s].uses_rs2 && busy_table_i[req_i[s].rs2];
            end
        end
    end

    // a written entry shows up as used one cycle later
    a_write_sets_used: assert property (
        @(posedge clk) disable iff (rst)
        |do_wr |=> (used_i & $past(wr_en_o[0] | wr_en_o[1])) == $past(wr_en_o[0] | wr_en_o[1])
    );

endmodule

// File: logic/rob_readout.sv
`timescale 1ns/100ps

module rob_readout (
    input  logic                                           clk,
    input  logic                                           rst,
    input  logic                                           global_wfi_i,
    input  rob_pkg::entry_view_t [rob_pkg::rob_size-1:0]   view_i,
    input  logic [rob_pkg::num_wb-1:0][rob_pkg::rob_idx_w-1:0] wb_idx_i,
    output logic [1:0]                                     commit_o,
    output logic [1:0][rob_pkg::pc_w-1:0]                  commit_pc_o,
    output logic [rob_pkg::rob_size-1:0]                   commit_clr_o,
    output logic [1:0]                                     fl_release_en_o,
    output logic [1:0][rob_pkg::preg_w-1:0]                fl_release_preg_o,
    output logic [rob_pkg::num_wb-1:0][rob_pkg::areg_w-1:0] wb_rd_o
);

    logic [rob_pkg::rob_idx_w-1:0]      cmt_ptr;
    logic [rob_pkg::rob_idx_w-1:0]      ptr_step;
    logic [1:0][rob_pkg::rob_idx_w-1:0] cidx;
    rob_pkg::entry_view_t               head0;
    rob_pkg::entry_view_t               head1;

    // ------------------------------------------------------------------
    // commit pointer
    // ------------------------------------------------------------------

    assign cidx[0] = cmt_ptr;
    assign cidx[1] = cmt_ptr + 1'b1;

    assign head0 = view_i[cidx[0]];
    assign head1 = view_i[cidx[1]];

    // oldest first and second only behind the first
    assign commit_o[0] = head0.used && head0.finish && !global_wfi_i;
    assign commit_o[1] = head1.used && head1.finish && commit_o[0];

    assign ptr_step = {{(rob_pkg::rob_idx_w-1){1'b0}}, commit_o[0]}
                    + {{(rob_pkg::rob_idx_w-1){1'b0}}, commit_o[1]};

    always_ff @(posedge clk) begin
        if (rst) begin
            cmt_ptr <= '0;
        end else begin
            cmt_ptr <= cmt_ptr + ptr_step;
        end
    end

    // clear strobes back to the entries
    always_comb begin
        for (int e = 0; e < rob_pkg::rob_size; e++) begin
            commit_clr_o[e] = (commit_o[0] && (int'(cidx[0]) == e))
                           || (commit_o[1] && (int'(cidx[1]) == e));
        end
    end

    // ------------------------------------------------------------------
    // commit report and free list release
    // ------------------------------------------------------------------

    assign commit_pc_o[0] = head0.pc;
    assign commit_pc_o[1] = head1.pc;

    // p0 is never returned
    assign fl_release_en_o[0]   = commit_o[0] && (head0.lprd != '0);
    assign fl_release_en_o[1]   = commit_o[1] && (head1.lprd != '0);
    assign fl_release_preg_o[0] = head0.lprd;
    assign fl_release_preg_o[1] = head1.lprd;

    // rd lookup for the writeback ports
    always_comb begin
        for (int w = 0; w < rob_pkg::num_wb; w++) begin
            wb_rd_o[w] = view_i[wb_idx_i[w]].rd;
        end
    end

    // the entry must drop out right after it retires
    a_commit_frees_entry: assert property (
        @(posedge clk) disable iff (rst)
        commit_o[0] |=> !view_i[$past(cidx[0])].used
    );

endmodule

// File: logic/rob_top.sv
`timescale 1ns/100ps

module rob_top (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic                                            global_wfi_i,
    input  logic [1:0]                                      valid_i,
    input  rob_pkg::decode_req_t [1:0]                      req_i,
    output logic [1:0]                                      ready_o,
    input  logic [rob_pkg::num_areg-1:0]                    busy_table_i,
    input  rob_pkg::fu_done_t [rob_pkg::num_fu-1:0]         fu_done_i,
    output rob_pkg::issue_pkt_t [1:0]                       issue_o,
    output logic [1:0]                                      fl_alloc_en_o,
    output logic [1:0]                                      commit_o,
    output logic [1:0][rob_pkg::pc_w-1:0]                   commit_pc_o,
    output logic [1:0]                                      fl_release_en_o,
    output logic [1:0][rob_pkg::preg_w-1:0]                 fl_release_preg_o,
    output logic [rob_pkg::num_wb-1:0][rob_pkg::areg_w-1:0] wb_rd_o
);

    logic [1:0][rob_pkg::rob_size-1:0]                  wr_en;
    rob_pkg::entry_wr_t [1:0]                           wr_data;
    rob_pkg::entry_view_t [rob_pkg::rob_size-1:0]       views;
    logic [rob_pkg::rob_size-1:0]                       used;
    logic [rob_pkg::rob_size-1:0]                       commit_clr;
    logic [rob_pkg::num_wb-1:0][rob_pkg::rob_idx_w-1:0] wb_idx;

    // writeback indices come straight from the done reports
    assign wb_idx[0] = fu_done_i[rob_pkg::fu_alu1].idx;
    assign wb_idx[1] = fu_done_i[rob_pkg::fu_alu2].idx;
    assign wb_idx[2] = fu_done_i[rob_pkg::fu_lsu].idx;

    rob_dispatch dispatch_i (
        .clk           (clk),
        .rst           (rst),
        .global_wfi_i  (global_wfi_i),
        .valid_i       (valid_i),
        .req_i         (req_i),
        .busy_table_i  (busy_table_i),
        .used_i        (used),
        .ready_o       (ready_o),
        .wr_en_o       (wr_en),
        .wr_data_o     (wr_data),
        .issue_o       (issue_o),
        .fl_alloc_en_o (fl_alloc_en_o)
    );

    // ------------------------------------------------------------------
    // entry array
    // ------------------------------------------------------------------

    for (genvar e = 0; e < rob_pkg::rob_size; e++) begin : g_entry
        assign used[e] = views[e].used;

        rob_entry #(
            .entry_idx (e)
        ) entry_i (
            .clk          (clk),
            .rst          (rst),
            .wr_en_i      ({wr_en[1][e], wr_en[0][e]}),
            .wr_data_i    (wr_data),
            .fu_done_i    (fu_done_i),
            .commit_clr_i (commit_clr[e]),
            .view_o       (views[e])
        );
    end

    rob_readout readout_i (
        .clk               (clk),
        .rst               (rst),
        .global_wfi_i      (global_wfi_i),
        .view_i            (views),
        .wb_idx_i          (wb_idx),
        .commit_o          (commit_o),
        .commit_pc_o       (commit_pc_o),
        .commit_clr_o      (commit_clr),
        .fl_release_en_o   (fl_release_en_o),
        .fl_release_preg_o (fl_release_preg_o),
        .wb_rd_o           (wb_rd_o)
    );

endmodule

// File: tests/rob_tb.sv
`timescale 1ns/100ps

module rob_tb;

    localparam int timeout_cycles = 400;

    logic                                            clk;
    logic                                            rst;
    logic                                            global_wfi_i;
    logic [1:0]                                      valid_i;
    rob_pkg::decode_req_t [1:0]                      req_i;
    logic [1:0]                                      ready_o;
    logic [rob_pkg::num_areg-1:0]                    busy_table_i;
    rob_pkg::fu_done_t [rob_pkg::num_fu-1:0]         fu_done_i;
    rob_pkg::issue_pkt_t [1:0]                       issue_o;
    logic [1:0]                                      fl_alloc_en_o;
    logic [1:0]                                      commit_o;
    logic [1:0][rob_pkg::pc_w-1:0]                   commit_pc_o;
    logic [1:0]                                      fl_release_en_o;
    logic [1:0][rob_pkg::preg_w-1:0]                 fl_release_preg_o;
    logic [rob_pkg::num_wb-1:0][rob_pkg::areg_w-1:0] wb_rd_o;

    // reference model with the oldest entry at the front
    logic [rob_pkg::pc_w-1:0]      pc_q[$];
    logic [rob_pkg::preg_w-1:0]    lprd_q[$];
    logic [rob_pkg::rob_idx_w-1:0] idx_q[$];
    logic                          m_used [rob_pkg::rob_size];
    logic                          m_fin  [rob_pkg::rob_size];
    logic [rob_pkg::areg_w-1:0]    m_rd   [rob_pkg::rob_size];
    logic [rob_pkg::rob_idx_w-1:0] m_wptr;
    int                            m_count;

    // expected values for the coming edge
    logic [1:0]                                      exp_ready;
    logic [1:0]                                      exp_alloc;
    logic [1:0]                                      exp_commit;
    logic [1:0]                                      exp_rel_en;
    logic [1:0][rob_pkg::pc_w-1:0]                   exp_cpc;
    logic [1:0][rob_pkg::preg_w-1:0]                 exp_preg;
    rob_pkg::issue_pkt_t [1:0]                       exp_iss;
    logic [rob_pkg::num_wb-1:0][rob_pkg::areg_w-1:0] exp_wb_rd;
    logic [1:0]                                      wr;
    logic [1:0][rob_pkg::preg_w-1:0]                 wr_lprd;

    int                       seed;
    int                       n;
    logic [31:0]              rnd;
    logic [1:0]               vpat;
    logic [rob_pkg::pc_w-1:0] pc_next;

    rob_top dut_i (
        .clk               (clk),
        .rst               (rst),
        .global_wfi_i      (global_wfi_i),
        .valid_i           (valid_i),
        .req_i             (req_i),
        .ready_o           (ready_o),
        .busy_table_i      (busy_table_i),
        .fu_done_i         (fu_done_i),
        .issue_o           (issue_o),
        .fl_alloc_en_o     (fl_alloc_en_o),
        .commit_o          (commit_o),
        .commit_pc_o       (commit_pc_o),
        .fl_release_en_o   (fl_release_en_o),
        .fl_release_preg_o (fl_release_preg_o),
        .wb_rd_o           (wb_rd_o)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("Mismatch %s: expected %0h, actual %0h", name, expected, actual);
        $display("*** TEST FAILED ***");
        $fatal(1, "check %s failed", name);
    endtask

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "run aborted");
    endtask

    // ------------------------------------------------------------------
    // model updated between edges while inputs are stable
    // ------------------------------------------------------------------

    always @(negedge clk) begin : model
        logic [rob_pkg::rob_idx_w-1:0] idx;
        if (rst) begin
            for (int e = 0; e < rob_pkg::rob_size; e++) begin
                m_used[e] = 1'b0;
                m_fin[e]  = 1'b0;
                m_rd[e]   = '0;
            end
            pc_q.delete();
            lprd_q.delete();
            idx_q.delete();
            m_wptr  = '0;
            m_count = 0;
        end
        for (int s = 0; s < 2; s++) begin
            idx                 = m_wptr + s;
            exp_ready[s]        = !m_used[idx];
            wr[s]               = valid_i[s] && exp_ready[s] && !global_wfi_i;
            exp_alloc[s]        = wr[s] && req_i[s].uses_rd && (req_i[s].rd != '0);
            exp_iss[s].rob_idx  = idx;
            exp_iss[s].pc       = req_i[s].pc;
            exp_iss[s].prd      = req_i[s].prd;
            exp_iss[s].prs1     = req_i[s].prs1;
            exp_iss[s].prs2     = req_i[s].prs2;
            exp_iss[s].rs1_wait = busy_table_i[req_i[s].rs1];
            exp_iss[s].rs2_wait = busy_table_i[req_i[s].rs2];
            wr_lprd[s]          = req_i[s].uses_rd ? req_i[s].lprd : '0;
        end
        // slot two reads or overwrites the rd that slot one just renamed
        if (req_i[0].uses_rd) begin
            if (req_i[1].rs1 == req_i[0].rd) begin
                exp_iss[1].prs1     = req_i[0].prd;
                exp_iss[1].rs1_wait = 1'b1;
            end
            if (req_i[1].rs2 == req_i[0].rd) begin
                exp_iss[1].prs2     = req_i[0].prd;
                exp_iss[1].rs2_wait = 1'b1;
            end
            if (req_i[1].uses_rd && (req_i[1].rd == req_i[0].rd)) begin
                wr_lprd[1] = req_i[0].prd;
            end
        end
        exp_commit = 2'b00;
        if (m_count > 0) begin
            exp_cpc[0]    = pc_q[0];
            exp_preg[0]   = lprd_q[0];
            exp_commit[0] = m_fin[idx_q[0]] && !global_wfi_i;
        end
        if (m_count > 1) begin
            exp_cpc[1]    = pc_q[1];
            exp_preg[1]   = lprd_q[1];
            exp_commit[1] = exp_commit[0] && m_fin[idx_q[1]];
        end
        exp_rel_en[0] = exp_commit[0] && (exp_preg[0] != '0);
        exp_rel_en[1] = exp_commit[1] && (exp_preg[1] != '0);
        exp_wb_rd[0]  = m_rd[fu_done_i[rob_pkg::fu_alu1].idx];
        exp_wb_rd[1]  = m_rd[fu_done_i[rob_pkg::fu_alu2].idx];
        exp_wb_rd[2]  = m_rd[fu_done_i[rob_pkg::fu_lsu].idx];

        if (!rst) begin
            for (int f = 0; f < rob_pkg::num_fu; f++) begin
                if (fu_done_i[f].valid) begin
                    m_fin[fu_done_i[f].idx] = 1'b1;
                end
            end
            for (int s = 0; s < 2; s++) begin
                if (exp_commit[s]) begin
                    idx = idx_q.pop_front();
                    pc_q.delete(0);
                    lprd_q.delete(0);
                    m_used[idx] = 1'b0;
                    m_fin[idx]  = 1'b0;
                    m_count--;
                end
            end
            for (int s = 0; s < 2; s++) begin
                if (wr[s]) begin
                    idx         = m_wptr + s;
                    m_used[idx] = 1'b1;
                    m_fin[idx]  = req_i[s].mret || req_i[s].sret || req_i[s].wfi;
                    m_rd[idx]   = req_i[s].uses_rd ? req_i[s].rd : '0;
                    pc_q.push_back(req_i[s].pc);
                    lprd_q.push_back(wr_lprd[s]);
                    idx_q.push_back(idx);
                    m_count++;
                end
            end
            m_wptr = m_wptr + wr[0] + wr[1];
        end
    end

    // ------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------

    a_ready: assert property (@(posedge clk) disable iff (rst) ready_o == exp_ready)
        else report_mismatch("ready", exp_ready, $sampled(ready_o));
    a_alloc: assert property (@(posedge clk) disable iff (rst) fl_alloc_en_o == exp_alloc)
        else report_mismatch("alloc enable", exp_alloc, $sampled(fl_alloc_en_o));
    a_commit: assert property (@(posedge clk) disable iff (rst) commit_o == exp_commit)
        else report_mismatch("commit", exp_commit, $sampled(commit_o));
    a_release: assert property (@(posedge clk) disable iff (rst) fl_release_en_o == exp_rel_en)
        else report_mismatch("release enable", exp_rel_en, $sampled(fl_release_en_o));
    // the model count already holds the state after this edge
    a_full: assert property (@(posedge clk) disable iff (rst)
        m_count == rob_pkg::rob_size |=> ready_o == 2'b00)
        else abort_run("ready stayed high with every entry in use");
    a_wfi_stall: assert property (@(posedge clk) disable iff (rst)
        global_wfi_i |-> commit_o == 2'b00 && fl_alloc_en_o == 2'b00)
        else abort_run("an entry was written or committed while wfi was high");

    for (genvar s = 0; s < 2; s++) begin : g_slot_chk
        a_rob_idx: assert property (@(posedge clk) disable iff (rst)
            valid_i[s] |-> issue_o[s].rob_idx == exp_iss[s].rob_idx)
            else report_mismatch("issue rob index", exp_iss[s].rob_idx,
                                 $sampled(issue_o[s].rob_idx));
        a_pc: assert property (@(posedge clk) disable iff (rst)
            valid_i[s] |-> issue_o[s].pc == exp_iss[s].pc)
            else report_mismatch("issue pc", exp_iss[s].pc, $sampled(issue_o[s].pc));
        a_prd: assert property (@(posedge clk) disable iff (rst)
            exp_alloc[s] |-> issue_o[s].prd == exp_iss[s].prd)
            else report_mismatch("issue prd", exp_iss[s].prd, $sampled(issue_o[s].prd));
        // source name with its wait bit
        a_src1: assert property (@(posedge clk) disable iff (rst)
            valid_i[s] && req_i[s].uses_rs1
            |-> {issue_o[s].prs1, issue_o[s].rs1_wait} == {exp_iss[s].prs1, exp_iss[s].rs1_wait})
            else report_mismatch("issue prs1 and wait", {exp_iss[s].prs1, exp_iss[s].rs1_wait},
                                 $sampled({issue_o[s].prs1, issue_o[s].rs1_wait}));
        a_src2: assert property (@(posedge clk) disable iff (rst)
            valid_i[s] && req_i[s].uses_rs2
            |-> {issue_o[s].prs2, issue_o[s].rs2_wait} == {exp_iss[s].prs2, exp_iss[s].rs2_wait})
            else report_mismatch("issue prs2 and wait", {exp_iss[s].prs2, exp_iss[s].rs2_wait},
                                 $sampled({issue_o[s].prs2, issue_o[s].rs2_wait}));
        a_commit_pc: assert property (@(posedge clk) disable iff (rst)
            commit_o[s] |-> commit_pc_o[s] == exp_cpc[s])
            else report_mismatch("commit pc", exp_cpc[s], $sampled(commit_pc_o[s]));
        a_release_preg: assert property (@(posedge clk) disable iff (rst)
            fl_release_en_o[s] |-> fl_release_preg_o[s] == exp_preg[s])
            else report_mismatch("release preg", exp_preg[s], $sampled(fl_release_preg_o[s]));
    end

    for (genvar w = 0; w < rob_pkg::num_wb; w++) begin : g_wb_chk
        localparam int unit = (w == 0) ? rob_pkg::fu_alu1
                            : (w == 1) ? rob_pkg::fu_alu2 : rob_pkg::fu_lsu;
        a_wb_rd: assert property (@(posedge clk) disable iff (rst)
            fu_done_i[unit].valid |-> wb_rd_o[w] == exp_wb_rd[w])
            else report_mismatch("writeback rd", exp_wb_rd[w], $sampled(wb_rd_o[w]));
    end

    // ------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------

    function automatic rob_pkg::decode_req_t random_req(input logic allow_skip);
        rob_pkg::decode_req_t r;
        logic [31:0]          rnd0;
        logic [31:0]          rnd1;
        rnd0       = $random(seed);
        rnd1       = $random(seed);
        r.pc       = pc_next;
        pc_next    = pc_next + 4;
        r.rs1      = rnd0[4:0];
        r.rs2      = rnd0[9:5];
        r.rd       = rnd0[14:10];
        r.uses_rs1 = rnd0[15];
        r.uses_rs2 = rnd0[16];
        r.uses_rd  = rnd0[17] | rnd0[18];
        // a few system instructions that need no unit
        r.mret     = allow_skip && (rnd0[21:19] == 3'd5);
        r.sret     = allow_skip && (rnd0[21:19] == 3'd6);
        r.wfi      = allow_skip && (rnd0[21:19] == 3'd7);
        r.prs1     = rnd1[5:0];
        r.prs2     = rnd1[11:6];
        r.lprd     = rnd1[17:12];
        r.prd      = rnd1[23:18];
        return r;
    endfunction

    // completion pulses for unfinished entries only and one unit per entry
    task automatic drive_done(input logic enable);
        logic [rob_pkg::rob_idx_w-1:0] cand[$];
        logic [31:0]                   r;
        int                            pick;
        fu_done_i = '0;
        if (enable) begin
            foreach (idx_q[k]) begin
                if (!m_fin[idx_q[k]]) begin
                    cand.push_back(idx_q[k]);
                end
            end
            for (int f = 0; f < rob_pkg::num_fu; f++) begin
                r = $random(seed);
                if (cand.size() > 0 && r[0]) begin
                    pick               = int'(r[15:1]) % cand.size();
                    fu_done_i[f].valid = 1'b1;
                    fu_done_i[f].idx   = cand[pick];
                    cand.delete(pick);
                end
            end
        end
    endtask

    task automatic drive_cycle(input logic [1:0] valid, input logic allow_done,
                               input logic allow_skip, input logic wfi);
        rob_pkg::decode_req_t r0;
        rob_pkg::decode_req_t r1;
        logic [31:0]          r;
        @(posedge clk);
        #0.5;
        r0 = random_req(allow_skip);
        r1 = random_req(allow_skip);
        r  = $random(seed);
        // force rd collisions inside the pair for the bypass
        if (r[2]) begin
            r0.uses_rd = 1'b1;
            case (r[1:0])
                2'd0: begin
                    r1.rs1      = r0.rd;
                    r1.uses_rs1 = 1'b1;
                end
                2'd1: begin
                    r1.rs2      = r0.rd;
                    r1.uses_rs2 = 1'b1;
                end
                default: begin
                    r1.rd      = r0.rd;
                    r1.uses_rd = 1'b1;
                end
            endcase
        end
        req_i        = {r1, r0};
        valid_i      = valid;
        global_wfi_i = wfi;
        busy_table_i = $random(seed);
        drive_done(allow_done);
    endtask

    initial begin
        seed         = 82;
        pc_next      = 'h1000;
        rst          = 1'b1;
        global_wfi_i = 1'b0;
        valid_i      = 2'b00;
        req_i        = '0;
        busy_table_i = '0;
        fu_done_i    = '0;
        repeat (5) @(posedge clk);
        #0.5;
        rst = 1'b0;

        // fill up with no completions and no skips
        n = 0;
        while (m_count < rob_pkg::rob_size) begin
            drive_cycle(2'b11, 1'b0, 1'b0, 1'b0);
            n++;
            if (n > timeout_cycles) begin
                abort_run("buffer did not fill up");
            end
        end
        repeat (4) drive_cycle(2'b11, 1'b0, 1'b0, 1'b0);

        // mixed traffic
        for (int c = 0; c < 400; c++) begin
            rnd  = $random(seed);
            vpat = (rnd[1:0] == 2'd0) ? 2'b00 : (rnd[1:0] == 2'd1) ? 2'b01 : 2'b11;
            drive_cycle(vpat, 1'b1, 1'b1, rnd[7:4] == 4'd0);
        end

        // drain
        n = 0;
        while (m_count > 0) begin
            drive_cycle(2'b00, 1'b1, 1'b0, 1'b0);
            n++;
            if (n > timeout_cycles) begin
                abort_run("buffer did not drain");
            end
        end
        repeat (3) drive_cycle(2'b00, 1'b0, 1'b0, 1'b0);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: rob_top.f
logic/rob_pkg.sv
logic/rob_entry.sv
logic/rob_dispatch.sv
logic/rob_readout.sv
logic/rob_top.sv
tests/rob_tb.sv

// File: Bender.yml
package:
  name: rob

sources:
  - logic/rob_pkg.sv
  - logic/rob_entry.sv
  - logic/rob_dispatch.sv
  - logic/rob_readout.sv
  - logic/rob_top.sv
  - target: test
    files:
      - tests/rob_tb.sv
